// ==== bench/riscv64_soc_tb.sv ====
`timescale 1ns/1ps
`include "riscv64_defs.svh"

module riscv64_soc_tb;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int RUN_CYCLES   = 24;
    localparam int ACK_TIMEOUT  = 20;
    // four tests with a reset and a run each plus two ack waits in the irq test
    localparam int TOTAL_CYCLES = 4 * (RESET_CYCLES + 2) + 4 * (RUN_CYCLES + 4)
                                + 2 * ACK_TIMEOUT;
    localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 100) * CLK_PERIOD;

    // instruction words built from the encoding rules
    localparam logic [31:0] NOP_WORD      = 32'h0000_0013;
    localparam logic [31:0] MRET_WORD     = 32'h0000_0000;
    localparam logic [31:0] LOADKEY_WORD  = 32'hFFFF_FFFF;
    localparam logic [31:0] STOREART_WORD = {20'hF_FFFF, 5'd30, 7'h7F};

    logic        clk;
    logic        reset;
    logic [31:0] instruction = NOP_WORD;
    logic [`RISCV64_IRQ_LINES-1:0] irq_lines;
    logic [63:0] key_data;
    logic        key_load;
    logic [31:0] pc;
    logic        heartbeat;
    logic        interrupt_pending;
    logic        interrupt_ack;
    logic [1:0]  interrupt_id;
    logic [63:0] art_data;
    logic        art_valid;

    // program image indexed by pc / 4
    logic [31:0] prog_mem [0:31];
    // test control and expectations
    string       test_name;
    logic        checks_on;
    logic        reset_check;
    logic        end_check;
    logic [63:0] exp_art;
    logic [1:0]  exp_id;
    int          exp_art_count;
    int          exp_ack_count;
    int          exp_repeat_count;
    logic [63:0] rng;
    logic [19:0] imm;
    // monitor state that clears while reset is low
    int          art_count;
    int          ack_count;
    int          repeat_count;
    logic        prev_valid;
    logic [31:0] prev_pc;
    logic [31:0] saved_pc;
    // one-cycle history for the relational checks
    logic [31:0] last_pc;
    logic        last_hb;
    logic        last_pending;
    logic [4:0]  ctrl_flags;

    riscv64_soc UUT (
        .clk               (clk),
        .reset             (reset),
        .instruction       (instruction),
        .irq_lines         (irq_lines),
        .key_data          (key_data),
        .key_load          (key_load),
        .pc                (pc),
        .heartbeat         (heartbeat),
        .interrupt_pending (interrupt_pending),
        .interrupt_ack     (interrupt_ack),
        .interrupt_id      (interrupt_id),
        .art_data          (art_data),
        .art_valid         (art_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [63:0] xorshift64(input logic [63:0] state);
        logic [63:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    // lui result is the upper immediate sign-extended to 64 bits
    function automatic logic [63:0] lui_value(input logic [19:0] value);
        return {{32{value[19]}}, value, 12'h000};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] value, input logic [4:0] rd);
        return {value, rd, 7'b0110111};
    endfunction

    // outside the image every word is a nop
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr[31:7] == '0) begin
            return prog_mem[addr[6:2]];
        end
        return NOP_WORD;
    endfunction

    // instruction model answering the current pc
    always @(negedge clk) begin
        instruction = fetch_word(pc);
    end

    // counts art pulses, acks and held pc values
    always @(negedge clk) begin
        if (!reset) begin
            art_count    = 0;
            ack_count    = 0;
            repeat_count = 0;
            prev_valid   = 1'b0;
        end else begin
            if (prev_valid && pc == prev_pc) begin
                repeat_count++;
            end
            if (art_valid) begin
                art_count++;
            end
            if (interrupt_ack) begin
                ack_count++;
                // pc of the cycle before entry is the return address
                saved_pc = prev_pc;
            end
            prev_valid = 1'b1;
        end
        prev_pc = pc;
    end

    always @(posedge clk) begin
        last_pc      <= pc;
        last_hb      <= heartbeat;
        last_pending <= interrupt_pending;
    end

    assign ctrl_flags = {art_valid, interrupt_ack, interrupt_pending,
                         UUT.u_core.bus_req.we, UUT.u_core.bus_req.re};

    task automatic report_mismatch(input string check, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("Mismatch %s in test %s: expected %h, actual %h",
                 check, test_name, expected, actual);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    reset_pc: assert property (@(posedge clk) disable iff (!reset)
        reset_check |-> pc == `RISCV64_RESET_PC)
        else report_mismatch("reset pc", 64'(`RISCV64_RESET_PC), 64'($sampled(pc)));

    // art_valid, ack, pending, we, re all low out of reset
    reset_flags: assert property (@(posedge clk) disable iff (!reset)
        reset_check |-> ctrl_flags == 5'b0)
        else report_mismatch("reset flags", 64'd0, 64'($sampled(ctrl_flags)));

    // jumps only on entry and on return and otherwise steps or stalls
    pc_step: assert property (@(posedge clk) disable iff (!reset)
        (checks_on && !interrupt_ack && !(last_pending && !interrupt_pending))
        |-> (pc == last_pc + 32'd4 || pc == last_pc))
        else report_mismatch("pc step", 64'($sampled(last_pc) + 32'd4), 64'($sampled(pc)));

    heartbeat_toggle: assert property (@(posedge clk) disable iff (!reset)
        checks_on |-> heartbeat != last_hb)
        else report_mismatch("heartbeat", 64'(!$sampled(last_hb)), 64'($sampled(heartbeat)));

    art_value: assert property (@(posedge clk) disable iff (!reset)
        art_valid |-> art_data == exp_art)
        else report_mismatch("art data", $sampled(exp_art), $sampled(art_data));

    ack_target: assert property (@(posedge clk) disable iff (!reset)
        interrupt_ack |-> pc == `RISCV64_ISR_PC)
        else report_mismatch("handler pc", 64'(`RISCV64_ISR_PC), 64'($sampled(pc)));

    ack_id: assert property (@(posedge clk) disable iff (!reset)
        interrupt_ack |-> interrupt_id == exp_id)
        else report_mismatch("interrupt id", 64'($sampled(exp_id)),
                             64'($sampled(interrupt_id)));

    // entry only from outside a handler with pending rising on the ack
    ack_masked: assert property (@(posedge clk) disable iff (!reset)
        interrupt_ack |-> {last_pending, interrupt_pending} == 2'b01)
        else report_mismatch("pending around ack", 64'd1,
                             64'({$sampled(last_pending), $sampled(interrupt_pending)}));

    mret_return: assert property (@(posedge clk) disable iff (!reset)
        (last_pending && !interrupt_pending) |-> pc == saved_pc)
        else report_mismatch("return pc", 64'($sampled(saved_pc)), 64'($sampled(pc)));

    art_pulses: assert property (@(posedge clk) disable iff (!reset)
        end_check |-> art_count == exp_art_count)
        else report_mismatch("art pulse count", 64'(exp_art_count), 64'(art_count));

    ack_pulses: assert property (@(posedge clk) disable iff (!reset)
        end_check |-> ack_count == exp_ack_count)
        else report_mismatch("ack count", 64'(exp_ack_count), 64'(ack_count));

    pc_repeats: assert property (@(posedge clk) disable iff (!reset)
        end_check |-> repeat_count == exp_repeat_count)
        else report_mismatch("pc repeat count", 64'(exp_repeat_count), 64'(repeat_count));

    // reset goes low here and the program is filled while it is held
    task automatic start_test(input string name);
        test_name = name;
        reset     = 1'b0;
        checks_on = 1'b0;
        for (int i = 0; i < 32; i++) begin
            prog_mem[i] = NOP_WORD;
        end
    endtask

    task automatic release_reset();
        repeat (RESET_CYCLES) @(negedge clk);
        reset       = 1'b1;
        reset_check = 1'b1;
        @(negedge clk);
        reset_check = 1'b0;
        checks_on   = 1'b1;
    endtask

    task automatic run_and_count(input int arts, input int acks, input int repeats);
        repeat (RUN_CYCLES) @(negedge clk);
        exp_art_count    = arts;
        exp_ack_count    = acks;
        exp_repeat_count = repeats;
        end_check        = 1'b1;
        @(negedge clk);
        end_check = 1'b0;
    endtask

    task automatic wait_for_ack();
        int waited;
        waited = 0;
        while (interrupt_ack !== 1'b1) begin
            if (waited == ACK_TIMEOUT) begin
                $display("no interrupt ack within %0d cycles in test %s",
                         ACK_TIMEOUT, test_name);
                $display("TEST FAILED");
                $fatal(1);
            end else begin
                waited++;
                @(negedge clk);
            end
        end
    endtask

    initial begin
        reset       = 1'b0;
        irq_lines   = '0;
        key_data    = 64'd0;
        key_load    = 1'b0;
        checks_on   = 1'b0;
        reset_check = 1'b0;
        end_check   = 1'b0;
        exp_art     = 64'd0;
        exp_id      = 2'd0;
        rng         = 64'd64;

        // straight nops for pc and heartbeat only
        start_test("reset_and_count");
        release_reset();
        run_and_count(0, 0, 0);

        // lui x5 at 44 and store at 48 with the sign bit forced on
        start_test("lui_store");
        rng          = xorshift64(rng);
        imm          = {1'b1, rng[18:0]};
        exp_art      = lui_value(imm);
        prog_mem[11] = lui_word(imm, 5'd5);
        prog_mem[12] = STOREART_WORD;
        release_reset();
        run_and_count(1, 0, 0);

        // key loaded before the loadkey at 52 gets to execute
        start_test("loadkey_store");
        rng          = xorshift64(rng);
        exp_art      = rng;
        prog_mem[13] = LOADKEY_WORD;
        prog_mem[14] = STOREART_WORD;
        release_reset();
        key_data = rng;
        key_load = 1'b1;
        @(negedge clk);
        key_load = 1'b0;
        run_and_count(1, 0, 1);

        // handler at 0 returns from 32
        start_test("irq_mret");
        prog_mem[8] = MRET_WORD;
        exp_id      = 2'd1;
        release_reset();
        repeat (4) @(negedge clk);
        irq_lines = 4'b1010;
        wait_for_ack();
        @(negedge clk);
        // new lines inside the handler wait for the return
        irq_lines = 4'b1100;
        exp_id    = 2'd2;
        wait_for_ack();
        @(negedge clk);
        irq_lines = '0;
        run_and_count(0, 2, 0);

        $display("TEST OK");
        $finish;
    end

    // hard stop if a test never reaches its end
    initial begin
        #WATCHDOG_NS;
        $display("watchdog expired in test %s before the tests finished", test_name);
        $display("TEST FAILED");
        $fatal(1);
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the soc testbench with verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f \
    --top-module riscv64_soc_tb -o riscv64_soc_sim

# status of the pipeline is the status of grep
./obj_dir/riscv64_soc_sim | tee /dev/stderr | grep -F -x "TEST OK" > /dev/null
echo "simulation passed"

// ==== verilog.f ====
+incdir+verilog
verilog/riscv64_pkg.sv
verilog/irq_controller.sv
verilog/riscv64_core.sv
verilog/io_bus.sv
verilog/riscv64_soc.sv
bench/riscv64_soc_tb.sv

// ==== verilog/io_bus.sv ====
`timescale 1ns/1ps
`include "riscv64_defs.svh"

module io_bus import riscv64_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  bus_req_t    bus_req,
    input  logic [63:0] key_data,
    input  logic        key_load,
    output logic [63:0] bus_rdata,
    output logic [63:0] art_data,
    output logic        art_valid
);

    // address hits
    logic       key_hit;
    logic       art_hit;
    // keyboard register
    logic [63:0] key_q;

    assign key_hit = bus_req.addr == `RISCV64_KEY_BASE;
    assign art_hit = bus_req.addr == `RISCV64_ART_BASE;

    // keyboard value loaded from outside
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            key_q <= '0;
        end else if (key_load) begin
            key_q <= key_data;
        end
    end

    // read data comes back in the strobe cycle
    // anything but a key read returns zero
    assign bus_rdata = (bus_req.re && key_hit) ? key_q : 64'd0;

    // art valid strobe
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            art_valid <= 1'b0;
        end else begin
            art_valid <= bus_req.we && art_hit;
        end
    end

    // art data only moves on a write to the port
    always_ff @(posedge clk) begin
        if (bus_req.we && art_hit) begin
            art_data <= bus_req.wdata;
        end
    end

    // every strobe has to land on a mapped register
    mapped_access: assert property (
        @(posedge clk) disable iff (!reset)
        (bus_req.we || bus_req.re) |-> (key_hit || art_hit)
    );

endmodule

// ==== verilog/irq_controller.sv ====
`timescale 1ns/1ps
`include "riscv64_defs.svh"

module irq_controller (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`RISCV64_IRQ_LINES-1:0] irq_lines,
    input  logic                          interrupt_pending,
    input  logic                          interrupt_ack,
    output logic                          irq_request,
    output logic [1:0]                    irq_id
);

    // two-flop synchronizer for the async lines
    logic [`RISCV64_IRQ_LINES-1:0] sync_1;
    logic [`RISCV64_IRQ_LINES-1:0] sync_2;
    // encoder output
    logic                          any_line;
    logic [1:0]                    enc_id;
    // captured request, kept until the core acks
    logic                          id_held;
    logic [1:0]                    id_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= irq_lines;
            sync_2 <= sync_1;
        end
    end

    // lowest-numbered active line wins
    // scan downward so the last hit is the lowest index
    always_comb begin
        any_line = |sync_2;
        enc_id   = 2'd0;
        for (int i = `RISCV64_IRQ_LINES - 1; i >= 0; i--) begin
            if (sync_2[i]) begin
                enc_id = 2'(i);
            end
        end
    end

    // latch the id on the first requesting cycle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            id_held <= 1'b0;
            id_q    <= 2'd0;
        end else if (interrupt_ack) begin
            id_held <= 1'b0;
        end else if (irq_request && !id_held) begin
            id_held <= 1'b1;
            id_q    <= enc_id;
        end
    end

    // masked while the core is inside a handler
    assign irq_request = !interrupt_pending && (any_line || id_held);
    assign irq_id      = id_held ? id_q : enc_id;

    // an ack only ever answers the request of the cycle before
    ack_follows_request: assert property (
        @(posedge clk) disable iff (!reset)
        interrupt_ack |-> $past(irq_request)
    );

endmodule

// ==== verilog/riscv64_core.sv ====
`timescale 1ns/1ps
`include "riscv64_defs.svh"

module riscv64_core import riscv64_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instruction,
    input  logic        irq_request,
    input  logic [1:0]  irq_id,
    input  logic [63:0] bus_rdata,
    output logic [31:0] pc,
    output logic        heartbeat,
    output logic        interrupt_pending,
    output logic        interrupt_ack,
    output logic [1:0]  interrupt_id,
    output bus_req_t    bus_req
);

    // fixed instruction words
    localparam logic [31:0] NOP_WORD      = 32'h0000_0001;
    localparam logic [31:0] MRET_WORD     = 32'h0000_0000;
    localparam logic [31:0] LOADKEY_WORD  = 32'hFFFF_FFFF;
    // all ones with rd = 30
    localparam logic [31:0] STOREART_WORD = 32'hFFFF_FF7F;
    localparam logic [6:0]  LUI_OPCODE    = 7'b0110111;

    // fetch register
    logic [31:0] ir;
    // decode
    op_t         op;
    logic [4:0]  rd;
    logic [63:0] imm_u;
    // execute state
    logic        bubble;
    load_step_t  load_step;
    logic [31:0] mepc;
    logic        exec_en;
    // register file and its single write port
    logic [63:0] regs [0:31];
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [63:0] rf_wdata;

    // fetch stage with the heartbeat riding along
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir        <= NOP_WORD;
            heartbeat <= 1'b0;
        end else begin
            ir        <= instruction;
            heartbeat <= ~heartbeat;
        end
    end

    // decode
    // the store pattern differs from the load one only in bit 7
    always_comb begin
        if (ir == LOADKEY_WORD) begin
            op = OP_LOADKEY;
        end else if (ir == STOREART_WORD) begin
            op = OP_STOREART;
        end else if (ir == MRET_WORD) begin
            op = OP_MRET;
        end else if (ir[6:0] == LUI_OPCODE) begin
            op = OP_LUI;
        end else begin
            op = OP_NOP;
        end
    end

    assign rd    = ir[11:7];
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};

    // ir only runs when no interrupt is taken and it is not squashed
    assign exec_en = !irq_request && !bubble;

    // write port
    // the key capture lands in the bubble cycle after the issue,
    // so it never competes with a lui
    always_comb begin
        rf_we    = 1'b0;
        rf_waddr = rd;
        rf_wdata = imm_u;
        if (load_step == LS_CAPTURE) begin
            rf_we    = 1'b1;
            rf_waddr = 5'd5;
            rf_wdata = bus_rdata;
        end else if (exec_en && op == OP_LUI) begin
            rf_we = 1'b1;
        end
    end

    // x0 is an ordinary register here
    always_ff @(posedge clk) begin
        if (rf_we) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // execute stage
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc                <= `RISCV64_RESET_PC;
            mepc              <= '0;
            bubble            <= 1'b0;
            load_step         <= LS_ISSUE;
            interrupt_pending <= 1'b0;
            interrupt_ack     <= 1'b0;
            interrupt_id      <= 2'd0;
            bus_req           <= '0;
        end else begin
            // by default pc steps to the next word and strobes and ack drop
            pc            <= pc + 32'd4;
            interrupt_ack <= 1'b0;
            bus_req.we    <= 1'b0;
            bus_req.re    <= 1'b0;

            // capture always finishes in one cycle
            if (load_step == LS_CAPTURE) begin
                load_step <= LS_ISSUE;
            end

            if (irq_request) begin
                // interrupt entry beats everything in ir
                mepc              <= pc;
                pc                <= `RISCV64_ISR_PC;
                bubble            <= 1'b1;
                interrupt_pending <= 1'b1;
                interrupt_ack     <= 1'b1;
                interrupt_id      <= irq_id;
            end else if (bubble) begin
                // squash the word fetched down the old path
                bubble <= 1'b0;
            end else begin
                case (op)
                    OP_MRET: begin
                        pc                <= mepc;
                        bubble            <= 1'b1;
                        interrupt_pending <= 1'b0;
                    end
                    OP_LOADKEY: begin
                        // read strobe out and pc frozen for a cycle
                        bus_req.addr <= `RISCV64_KEY_BASE;
                        bus_req.re   <= 1'b1;
                        pc           <= pc;
                        bubble       <= 1'b1;
                        load_step    <= LS_CAPTURE;
                    end
                    OP_STOREART: begin
                        bus_req.addr  <= `RISCV64_ART_BASE;
                        bus_req.wdata <= regs[5];
                        bus_req.we    <= 1'b1;
                    end
                    default: begin
                        // lui goes through the write port and nop does nothing
                    end
                endcase
            end
        end
    end

    // one access at a time on the bus
    no_read_and_write: assert property (
        @(posedge clk) disable iff (!reset)
        !(bus_req.we && bus_req.re)
    );

    // the held pc cycle is also the one that completes the load into x5
    pc_held_for_load: assert property (
        @(posedge clk) disable iff (!reset)
        load_step == LS_CAPTURE |-> pc == $past(pc) && rf_we && rf_waddr == 5'd5
    );

endmodule

// ==== verilog/riscv64_defs.svh ====
`ifndef RISCV64_DEFS_SVH
`define RISCV64_DEFS_SVH

// pc value right after reset
`define RISCV64_RESET_PC 32'd44

// handler entry, pc jumps here on interrupt
`define RISCV64_ISR_PC 32'd0

// keyboard data register, read only
`define RISCV64_KEY_BASE 64'h0000_0000_8000_0008

// art output port, write only
`define RISCV64_ART_BASE 64'h0000_0000_8000_0000

// number of external interrupt lines
`define RISCV64_IRQ_LINES 4

`endif

// ==== verilog/riscv64_pkg.sv ====
package riscv64_pkg;

    // decoded instruction class
    // every word that matches none of the patterns is a nop
    typedef enum logic [2:0] {
        OP_NOP      = 3'd0,
        OP_LUI      = 3'd1,
        OP_MRET     = 3'd2,
        OP_LOADKEY  = 3'd3,
        OP_STOREART = 3'd4
    } op_t;

    // two-step keyboard load
    // issue puts the read strobe out, capture takes the data into x5
    typedef enum logic {
        LS_ISSUE   = 1'b0,
        LS_CAPTURE = 1'b1
    } load_step_t;

    // core to io bus request
    // we and re are one-cycle strobes
    // addr and wdata stay put between accesses
    typedef struct packed {
        // byte address on the io bus
        logic [63:0] addr;
        // store data, only meaningful with we
        logic [63:0] wdata;
        // write strobe
        logic        we;
        // read strobe
        logic        re;
    } bus_req_t;

endpackage

// ==== verilog/riscv64_soc.sv ====
`timescale 1ns/1ps
`include "riscv64_defs.svh"

module riscv64_soc import riscv64_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [31:0]                   instruction,
    input  logic [`RISCV64_IRQ_LINES-1:0] irq_lines,
    input  logic [63:0]                   key_data,
    input  logic                          key_load,
    output logic [31:0]                   pc,
    output logic                          heartbeat,
    output logic                          interrupt_pending,
    output logic                          interrupt_ack,
    output logic [1:0]                    interrupt_id,
    output logic [63:0]                   art_data,
    output logic                          art_valid
);

    // core <-> io bus
    bus_req_t    bus_req;
    logic [63:0] bus_rdata;
    // interrupt controller -> core
    logic        irq_request;
    logic [1:0]  irq_id;

    irq_controller u_irq (
        .clk               (clk),
        .reset             (reset),
        .irq_lines         (irq_lines),
        .interrupt_pending (interrupt_pending),
        .interrupt_ack     (interrupt_ack),
        .irq_request       (irq_request),
        .irq_id            (irq_id)
    );

    riscv64_core u_core (
        .clk               (clk),
        .reset             (reset),
        .instruction       (instruction),
        .irq_request       (irq_request),
        .irq_id            (irq_id),
        .bus_rdata         (bus_rdata),
        .pc                (pc),
        .heartbeat         (heartbeat),
        .interrupt_pending (interrupt_pending),
        .interrupt_ack     (interrupt_ack),
        .interrupt_id      (interrupt_id),
        .bus_req           (bus_req)
    );

    io_bus u_io (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .key_data  (key_data),
        .key_load  (key_load),
        .bus_rdata (bus_rdata),
        .art_data  (art_data),
        .art_valid (art_valid)
    );

endmodule
